// File: files.f
+incdir+logic
+incdir+test
logic/mac_table_pkg.sv
logic/mac_table_ram.sv
logic/dst_match.sv
logic/src_check.sv
logic/pending_queue.sv
logic/learn_arbiter.sv
logic/mac_table_top.sv
test/mac_table_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mac_table_tb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' files.f) logic/mac_table_defs.svh test/mac_table_ref.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || \
		! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/mac_table_ref.svh
`ifndef MAC_TABLE_REF_SVH
`define MAC_TABLE_REF_SVH

// Table model, one slot per row and way
logic ref_valid [`TABLE_ROWS][`ASSOC_WAYS];
logic [`VLAN_W-1:0] ref_vlan [`TABLE_ROWS][`ASSOC_WAYS];
logic [`PORT_W-1:0] ref_port [`TABLE_ROWS][`ASSOC_WAYS];
logic [`MAC_W-1:0] ref_mac [`TABLE_ROWS][`ASSOC_WAYS];
// Column that the next learned source takes
int ref_repl;

// Row index, three 16-bit MAC slices and the VLAN folded by XOR
function automatic logic [`ROW_BITS-1:0] fold_row(input logic [`MAC_W-1:0] mac,
	input logic [`VLAN_W-1:0] vlan);
	logic [15:0] f;
	f = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {{(16 - `VLAN_W){1'b0}}, vlan};
	return f[`ROW_BITS-1:0];
endfunction

function automatic void clear_table();
	for (int r = 0; r < `TABLE_ROWS; r++) begin
		for (int w = 0; w < `ASSOC_WAYS; w++) begin
			ref_valid[r][w] = 1'b0;
			ref_vlan[r][w] = '0;
			ref_port[r][w] = '0;
			ref_mac[r][w] = '0;
		end
	end
	ref_repl = 0;
endfunction

// A source is known on VLAN and MAC alone
function automatic logic source_known(input logic [`MAC_W-1:0] mac,
	input logic [`VLAN_W-1:0] vlan);
	logic [`ROW_BITS-1:0] r;
	logic found;
	r = fold_row(mac, vlan);
	found = 1'b0;
	for (int w = 0; w < `ASSOC_WAYS; w++) begin
		if (ref_valid[r][w] && (ref_vlan[r][w] == vlan) && (ref_mac[r][w] == mac)) begin
			found = 1'b1;
		end
	end
	return found;
endfunction

// Sequential replacement, wraps after the last way
function automatic void advance_column();
	ref_repl = (ref_repl + 1) % `ASSOC_WAYS;
endfunction

// One request in order: destination result first, then source learning
function automatic void ref_lookup(input logic [`VLAN_W-1:0] vlan,
	input logic [`MAC_W-1:0] src, input logic [`PORT_W-1:0] sport,
	input logic [`MAC_W-1:0] dst, output logic hit, output logic [`PORT_W-1:0] port);
	logic [`ROW_BITS-1:0] r;
	hit = 1'b0;
	port = '0;
	r = fold_row(dst, vlan);
	// Later ways overwrite earlier ones, highest match wins
	for (int w = 0; w < `ASSOC_WAYS; w++) begin
		if (ref_valid[r][w] && (ref_vlan[r][w] == vlan) && (ref_mac[r][w] == dst)) begin
			hit = 1'b1;
			port = ref_port[r][w];
		end
	end
	if (!source_known(src, vlan)) begin
		r = fold_row(src, vlan);
		ref_valid[r][ref_repl] = 1'b1;
		ref_vlan[r][ref_repl] = vlan;
		ref_port[r][ref_repl] = sport;
		ref_mac[r][ref_repl] = src;
		advance_column();
	end
endfunction

`endif

// File: test/mac_table_tb.sv
`default_nettype none
`include "mac_table_defs.svh"

module mac_table_tb;

	// Idle cycles after a spaced request let a learn land
	localparam int SPACE = 12;
	localparam int DRAIN = 16;
	// Cycles from issue to lookup_done before it counts as missing
	localparam int LAT_MAX = 6;
	// Edges from driving a request to sampling its lookup_done
	localparam int DONE_LAG = 4;
	localparam int N_EMPTY = 6;
	localparam int N_LEARN = 6;
	localparam int N_BURST = 20;
	localparam int N_QUEUE = 8;
	localparam int N_SPACED = N_EMPTY + 3 * N_LEARN + 1 + 6 + 1 + 2 + `PENDING_DEPTH;
	localparam int LIMIT_CYCLES = N_SPACED * (SPACE + 1) + N_BURST + 3 + N_QUEUE +
		4 * DRAIN + 3 + 50;

	logic clk = 1'b0;
	logic rst_n;
	logic lookup_valid;
	logic [`VLAN_W-1:0] lookup_vlan;
	logic [`MAC_W-1:0] lookup_src_mac;
	logic [`PORT_W-1:0] lookup_src_port;
	logic [`MAC_W-1:0] lookup_dst_mac;
	wire lookup_done;
	wire lookup_hit;
	wire [`PORT_W-1:0] lookup_dst_port;

	// Expected results in issue order
	string name_q [$];
	logic exp_hit_q [$];
	logic [`PORT_W-1:0] exp_port_q [$];
	int issue_q [$];

	int cycle = 0;
	int checks = 0;
	int mismatches = 0;
	int other_errs = 0;

	`include "mac_table_ref.svh"

	mac_table_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_valid(lookup_valid),
		.lookup_vlan(lookup_vlan),
		.lookup_src_mac(lookup_src_mac),
		.lookup_src_port(lookup_src_port),
		.lookup_dst_mac(lookup_dst_mac),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_dst_port(lookup_dst_port)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [`MAC_W-1:0] rand_mac();
		logic [`MAC_W-1:0] m;
		m[31:0] = $urandom;
		m[47:32] = 16'($urandom);
		return m;
	endfunction

	// Random MAC steered into a given row through its low nibble
	function automatic logic [`MAC_W-1:0] mac_in_row(input logic [`VLAN_W-1:0] vlan,
		input logic [`ROW_BITS-1:0] row);
		logic [`MAC_W-1:0] m;
		m = rand_mac();
		m[`ROW_BITS-1:0] = m[`ROW_BITS-1:0] ^ fold_row(m, vlan) ^ row;
		return m;
	endfunction

	// Holds the request for one cycle from a rising edge
	task automatic send_lookup(input string name, input logic [`VLAN_W-1:0] vlan,
		input logic [`MAC_W-1:0] src, input logic [`PORT_W-1:0] sport,
		input logic [`MAC_W-1:0] dst);
		logic hit;
		logic [`PORT_W-1:0] port;
		ref_lookup(vlan, src, sport, dst, hit, port);
		name_q.push_back(name);
		exp_hit_q.push_back(hit);
		exp_port_q.push_back(port);
		issue_q.push_back(cycle);
		lookup_valid <= 1'b1;
		lookup_vlan <= vlan;
		lookup_src_mac <= src;
		lookup_src_port <= sport;
		lookup_dst_mac <= dst;
		@(posedge clk);
	endtask

	task automatic idle_cycles(input int n);
		lookup_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	// Request then a quiet gap so the model stays exact
	task automatic send_spaced(input string name, input logic [`VLAN_W-1:0] vlan,
		input logic [`MAC_W-1:0] src, input logic [`PORT_W-1:0] sport,
		input logic [`MAC_W-1:0] dst);
		send_lookup(name, vlan, src, sport, dst);
		idle_cycles(SPACE);
	endtask

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errs);
		if (mismatches == 0 && other_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result compare

	always @(posedge clk) begin : compare
		string nm;
		logic eh;
		logic [`PORT_W-1:0] ep;
		int iss;
		if (lookup_done) begin
			if (exp_hit_q.size() == 0) begin
				other_errs++;
				$display("ERROR: lookup_done with no request outstanding, cycle %0d", cycle);
			end else begin
				nm = name_q.pop_front();
				eh = exp_hit_q.pop_front();
				ep = exp_port_q.pop_front();
				iss = issue_q.pop_front();
				checks++;
				if ((cycle - iss) != DONE_LAG) begin
					mismatches++;
					$display("mismatch %s: lookup_done latency expected %0d actual %0d", nm,
						DONE_LAG, cycle - iss);
				end
				if (lookup_hit !== eh) begin
					mismatches++;
					$display("mismatch %s: lookup_hit expected %0b actual %0b", nm, eh,
						lookup_hit);
				end
				if (lookup_dst_port !== ep) begin
					mismatches++;
					$display("mismatch %s: lookup_dst_port expected %0d actual %0d", nm, ep,
						lookup_dst_port);
				end
			end
		end else if (issue_q.size() > 0 && (cycle - issue_q[0]) > LAT_MAX) begin
			// Drop an overdue request so later ones still line up
			nm = name_q.pop_front();
			eh = exp_hit_q.pop_front();
			ep = exp_port_q.pop_front();
			iss = issue_q.pop_front();
			other_errs++;
			$display("ERROR: %s request issued at cycle %0d got no lookup_done", nm, iss);
		end
	end

	// Watchdog sized from the request count and the idle gaps
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		other_errs++;
		$display("ERROR: watchdog expired after %0d cycles", LIMIT_CYCLES);
		finish_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [`VLAN_W-1:0] vlan_a;
		logic [`VLAN_W-1:0] vlan_b;
		logic [`MAC_W-1:0] lrn_mac [N_LEARN];
		logic [`PORT_W-1:0] lrn_port [N_LEARN];
		logic [`MAC_W-1:0] probe_mac;
		logic [`PORT_W-1:0] probe_port;
		logic [`MAC_W-1:0] grp_mac [3];
		logic [`MAC_W-1:0] nb_mac;
		logic [`PORT_W-1:0] nb_port;
		logic [`MAC_W-1:0] dup_mac;
		logic [`PORT_W-1:0] dup_port;
		logic [`MAC_W-1:0] q_mac [N_QUEUE];
		int k;

		void'($urandom(32'h164a03af));
		rst_n <= 1'b0;
		lookup_valid <= 1'b0;
		lookup_vlan <= '0;
		lookup_src_mac <= '0;
		lookup_src_port <= '0;
		lookup_dst_mac <= '0;
		clear_table();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Random keys all miss in the empty table
		for (int i = 0; i < N_EMPTY; i++) begin
			send_spaced("empty_miss", 12'($urandom), rand_mac(), 5'($urandom), rand_mac());
		end

		// One source per row 0 to 5 and a probe in a second VLAN
		vlan_a = 12'($urandom);
		// Second VLAN keeps the row bits so the same MAC lands in the same row
		vlan_b = vlan_a ^ 12'h5a0;
		for (int i = 0; i < N_LEARN; i++) begin
			lrn_mac[i] = mac_in_row(vlan_a, `ROW_BITS'(i));
			lrn_port[i] = 5'($urandom);
			send_spaced("learn", vlan_a, lrn_mac[i], lrn_port[i], rand_mac());
		end
		probe_mac = mac_in_row(vlan_b, `ROW_BITS'(15));
		probe_port = 5'($urandom);
		send_spaced("learn", vlan_b, probe_mac, probe_port, rand_mac());

		// Known sources only so the table holds still
		for (int i = 0; i < N_LEARN; i++) begin
			send_spaced("learn_hit", vlan_a, lrn_mac[0], lrn_port[0], lrn_mac[i]);
		end
		for (int i = 0; i < N_LEARN; i++) begin
			send_spaced("vlan_miss", vlan_b, probe_mac, probe_port, lrn_mac[i]);
		end

		// Three sources on row 8 where the third takes the first one's column
		for (int i = 0; i < 3; i++) begin
			grp_mac[i] = mac_in_row(vlan_a, `ROW_BITS'(8));
			send_spaced("replace", vlan_a, grp_mac[i], 5'($urandom), rand_mac());
		end
		for (int i = 0; i < 3; i++) begin
			send_spaced("replace", vlan_a, lrn_mac[0], lrn_port[0], grp_mac[i]);
		end

		// Back to back with every source already in the table
		for (int i = 0; i < N_BURST; i++) begin
			k = $urandom_range(N_LEARN - 1, 0);
			if (i % 5 == 4) begin
				send_lookup("burst", vlan_b, probe_mac, probe_port, lrn_mac[k]);
			end else begin
				send_lookup("burst", vlan_a, lrn_mac[i % N_LEARN], lrn_port[i % N_LEARN],
					lrn_mac[k]);
			end
		end
		idle_cycles(DRAIN);

		// Neighbour on row 10 holds the column a second learn of the duplicate would take
		nb_mac = mac_in_row(vlan_a, `ROW_BITS'(10));
		nb_port = 5'($urandom);
		send_spaced("dup_learn", vlan_a, nb_mac, nb_port, rand_mac());

		// Same new source three cycles running
		dup_mac = mac_in_row(vlan_a, `ROW_BITS'(10));
		dup_port = 5'($urandom);
		for (int i = 0; i < 3; i++) begin
			send_lookup("dup_learn", vlan_a, dup_mac, dup_port, lrn_mac[i + 1]);
			// Repeat misses still step the column counter
			if (i > 0) begin
				advance_column();
			end
		end
		idle_cycles(DRAIN);
		send_spaced("dup_learn", vlan_a, lrn_mac[0], lrn_port[0], dup_mac);
		send_spaced("dup_learn", vlan_a, lrn_mac[0], lrn_port[0], nb_mac);

		// Queue overrun on rows 6 to 13 away from row 0
		for (int i = 0; i < N_QUEUE; i++) begin
			q_mac[i] = mac_in_row(vlan_a, `ROW_BITS'(6 + i));
			send_lookup("queue_fill", vlan_a, q_mac[i], 5'($urandom), rand_mac());
		end
		idle_cycles(DRAIN);
		// Only the sources that fit in the queue are checked
		for (int i = 0; i < `PENDING_DEPTH; i++) begin
			send_spaced("queue_fill", vlan_a, lrn_mac[0], lrn_port[0], q_mac[i]);
		end

		idle_cycles(DRAIN);
		if (exp_hit_q.size() != 0) begin
			other_errs++;
			$display("ERROR: %0d lookups never completed", exp_hit_q.size());
		end
		finish_run();
	end

endmodule

`default_nettype wire

// File: logic/mac_table_top.sv
`default_nettype none
`include "mac_table_defs.svh"

module mac_table_top import mac_table_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire lookup_valid,
	input wire [`VLAN_W-1:0] lookup_vlan,
	input wire [`MAC_W-1:0] lookup_src_mac,
	input wire [`PORT_W-1:0] lookup_src_port,
	input wire [`MAC_W-1:0] lookup_dst_mac,
	output logic lookup_done,
	output logic lookup_hit,
	output logic [`PORT_W-1:0] lookup_dst_port
);

	// Port A
	logic a_en;
	logic [`ROW_BITS-1:0] a_row;
	mac_entry_u [`ASSOC_WAYS-1:0] a_rdata;

	// Port B
	logic b_en;
	logic [`ROW_BITS-1:0] b_row;
	logic [`ASSOC_WAYS-1:0] b_we;
	logic [`ENTRY_W-1:0] b_wdata;
	mac_entry_u [`ASSOC_WAYS-1:0] b_rdata;

	// Learn path
	logic [`ROW_BITS-1:0] src_row;
	logic learn_req;
	logic [`VLAN_W-1:0] learn_vlan;
	logic [`MAC_W-1:0] learn_mac;
	logic [`PORT_W-1:0] learn_port;
	logic [`WAY_BITS-1:0] learn_way;
	logic pend_avail;
	logic [`ROW_BITS-1:0] pend_row;
	logic [`WAY_BITS-1:0] pend_way;
	mac_entry_u pend_word;
	logic pend_pop;

	////////////////////////////////////////////////////////////////////////////
	// Table and lookup

	mac_table_ram u_ram (
		.clk(clk),
		.rst_n(rst_n),
		.a_en(a_en),
		.a_row(a_row),
		.b_en(b_en),
		.b_row(b_row),
		.b_we(b_we),
		.b_wdata(b_wdata),
		.a_rdata(a_rdata),
		.b_rdata(b_rdata)
	);

	dst_match u_dst (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_valid(lookup_valid),
		.lookup_vlan(lookup_vlan),
		.lookup_dst_mac(lookup_dst_mac),
		.a_rdata(a_rdata),
		.a_en(a_en),
		.a_row(a_row),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_dst_port(lookup_dst_port)
	);

	////////////////////////////////////////////////////////////////////////////
	// Source learning

	src_check u_src (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_valid(lookup_valid),
		.lookup_vlan(lookup_vlan),
		.lookup_src_mac(lookup_src_mac),
		.lookup_src_port(lookup_src_port),
		.b_rdata(b_rdata),
		.src_row(src_row),
		.learn_req(learn_req),
		.learn_vlan(learn_vlan),
		.learn_mac(learn_mac),
		.learn_port(learn_port),
		.learn_way(learn_way)
	);

	pending_queue u_pend (
		.clk(clk),
		.rst_n(rst_n),
		.learn_req(learn_req),
		.learn_vlan(learn_vlan),
		.learn_mac(learn_mac),
		.learn_port(learn_port),
		.learn_way(learn_way),
		.pend_pop(pend_pop),
		.pend_avail(pend_avail),
		.pend_row(pend_row),
		.pend_way(pend_way),
		.pend_word(pend_word)
	);

	learn_arbiter u_arb (
		.lookup_valid(lookup_valid),
		.src_row(src_row),
		.pend_avail(pend_avail),
		.pend_row(pend_row),
		.pend_way(pend_way),
		.pend_word(pend_word),
		.b_en(b_en),
		.b_row(b_row),
		.b_we(b_we),
		.b_wdata(b_wdata),
		.pend_pop(pend_pop)
	);

endmodule

`default_nettype wire

// File: logic/learn_arbiter.sv
`default_nettype none
`include "mac_table_defs.svh"

module learn_arbiter import mac_table_pkg::*; (
	input wire lookup_valid,
	input wire [`ROW_BITS-1:0] src_row,
	input wire pend_avail,
	input wire [`ROW_BITS-1:0] pend_row,
	input wire [`WAY_BITS-1:0] pend_way,
	input wire mac_entry_u pend_word,
	output logic b_en,
	output logic [`ROW_BITS-1:0] b_row,
	output logic [`ASSOC_WAYS-1:0] b_we,
	output logic [`ENTRY_W-1:0] b_wdata,
	output logic pend_pop
);

	////////////////////////////////////////////////////////////////////////////
	// Port B owner per cycle

	// Source read first, then a queued write
	// No lookup and nothing pending leaves the port idle
	always_comb begin
		b_en = 1'b0;
		b_row = '0;
		b_we = '0;
		b_wdata = '0;
		pend_pop = 1'b0;

		if (lookup_valid) begin
			// Source row read, no strobes
			b_en = 1'b1;
			b_row = src_row;
		end else if (pend_avail) begin
			// Head entry into its own column
			b_en = 1'b1;
			b_row = pend_row;
			b_we[pend_way] = 1'b1;
			b_wdata = pend_word.raw;
			// Slot frees at the same edge as the write
			pend_pop = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/pending_queue.sv
`default_nettype none
`include "mac_table_defs.svh"

module pending_queue import mac_table_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire learn_req,
	input wire [`VLAN_W-1:0] learn_vlan,
	input wire [`MAC_W-1:0] learn_mac,
	input wire [`PORT_W-1:0] learn_port,
	input wire [`WAY_BITS-1:0] learn_way,
	input wire pend_pop,
	output logic pend_avail,
	output logic [`ROW_BITS-1:0] pend_row,
	output logic [`WAY_BITS-1:0] pend_way,
	output mac_entry_u pend_word
);

	logic [`PENDING_DEPTH-1:0] slot_v;
	logic [`MAC_W-1:0] slot_mac [`PENDING_DEPTH];
	logic [`VLAN_W-1:0] slot_vlan [`PENDING_DEPTH];
	logic [`PORT_W-1:0] slot_port [`PENDING_DEPTH];
	logic [`WAY_BITS-1:0] slot_way [`PENDING_DEPTH];
	logic dup;
	logic have_free;
	logic [`PEND_BITS-1:0] free_idx;
	logic [`PEND_BITS-1:0] head_idx;
	logic do_insert;

	////////////////////////////////////////////////////////////////////////////
	// Slot search

	always_comb begin
		dup = 1'b0;
		have_free = 1'b0;
		free_idx = '0;
		head_idx = '0;
		// Downward scan, lowest index ends up in free_idx and head_idx
		for (int i = `PENDING_DEPTH - 1; i >= 0; i--) begin
			if (slot_v[i] && (slot_mac[i] == learn_mac) && (slot_vlan[i] == learn_vlan) &&
				(slot_port[i] == learn_port)) begin
				dup = 1'b1;
			end
			if (slot_v[i]) begin
				head_idx = `PEND_BITS'(i);
			end else begin
				have_free = 1'b1;
				free_idx = `PEND_BITS'(i);
			end
		end
	end

	// Full queue drops a new address
	assign do_insert = learn_req && !dup && have_free;

	// Head entry, packed as a valid table word
	assign pend_avail = |slot_v;
	assign pend_row = row_index_hash(slot_mac[head_idx], slot_vlan[head_idx]);
	assign pend_way = slot_way[head_idx];

	always_comb begin
		pend_word.fld.valid = 1'b1;
		pend_word.fld.vlan = slot_vlan[head_idx];
		pend_word.fld.port = slot_port[head_idx];
		pend_word.fld.mac = slot_mac[head_idx];
	end

	// Pop and insert never hit the same slot
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_v <= '0;
		end else begin
			if (pend_pop && pend_avail) begin
				slot_v[head_idx] <= 1'b0;
			end
			if (do_insert) begin
				slot_v[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_insert) begin
			slot_mac[free_idx] <= learn_mac;
			slot_vlan[free_idx] <= learn_vlan;
			slot_port[free_idx] <= learn_port;
			slot_way[free_idx] <= learn_way;
		end
	end

endmodule

`default_nettype wire

// File: logic/src_check.sv
`default_nettype none
`include "mac_table_defs.svh"

module src_check import mac_table_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire lookup_valid,
	input wire [`VLAN_W-1:0] lookup_vlan,
	input wire [`MAC_W-1:0] lookup_src_mac,
	input wire [`PORT_W-1:0] lookup_src_port,
	input wire mac_entry_u [`ASSOC_WAYS-1:0] b_rdata,
	output logic [`ROW_BITS-1:0] src_row,
	output logic learn_req,
	output logic [`VLAN_W-1:0] learn_vlan,
	output logic [`MAC_W-1:0] learn_mac,
	output logic [`PORT_W-1:0] learn_port,
	output logic [`WAY_BITS-1:0] learn_way
);

	localparam int LAST_WAY = `ASSOC_WAYS - 1;

	logic [1:0] vld_d;
	logic [`VLAN_W-1:0] vlan_d [2];
	logic [`MAC_W-1:0] mac_d [2];
	logic [`PORT_W-1:0] port_d [2];
	logic known_c;
	logic miss;
	// Sequential replacement column
	logic [`WAY_BITS-1:0] repl_q;

	assign src_row = row_index_hash(lookup_src_mac, lookup_vlan);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_d <= '0;
		end else begin
			vld_d <= {vld_d[0], lookup_valid};
		end
	end

	// Source key follows the port B read
	always_ff @(posedge clk) begin
		vlan_d[0] <= lookup_vlan;
		vlan_d[1] <= vlan_d[0];
		mac_d[0] <= lookup_src_mac;
		mac_d[1] <= mac_d[0];
		port_d[0] <= lookup_src_port;
		port_d[1] <= port_d[0];
	end

	// Source counts as known on VLAN and MAC, port not checked
	always_comb begin
		known_c = 1'b0;
		for (int w = 0; w < `ASSOC_WAYS; w++) begin
			if (b_rdata[w].fld.valid && (b_rdata[w].fld.vlan == vlan_d[1]) &&
				(b_rdata[w].fld.mac == mac_d[1])) begin
				known_c = 1'b1;
			end
		end
	end

	assign miss = vld_d[1] && !known_c;

	////////////////////////////////////////////////////////////////////////////
	// Learn request and column counter

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			learn_req <= 1'b0;
			repl_q <= '0;
		end else begin
			learn_req <= miss;
			// Every miss bumps the column, duplicates included
			if (miss) begin
				repl_q <= (repl_q == LAST_WAY[`WAY_BITS-1:0]) ? '0 : repl_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (miss) begin
			learn_vlan <= vlan_d[1];
			learn_mac <= mac_d[1];
			learn_port <= port_d[1];
			learn_way <= repl_q;
		end
	end

endmodule

`default_nettype wire

// File: logic/dst_match.sv
`default_nettype none
`include "mac_table_defs.svh"

module dst_match import mac_table_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire lookup_valid,
	input wire [`VLAN_W-1:0] lookup_vlan,
	input wire [`MAC_W-1:0] lookup_dst_mac,
	input wire mac_entry_u [`ASSOC_WAYS-1:0] a_rdata,
	output logic a_en,
	output logic [`ROW_BITS-1:0] a_row,
	output logic lookup_done,
	output logic lookup_hit,
	output logic [`PORT_W-1:0] lookup_dst_port
);

	logic [1:0] vld_d;
	logic [`VLAN_W-1:0] vlan_d [2];
	logic [`MAC_W-1:0] mac_d [2];
	logic hit_c;
	logic [`PORT_W-1:0] port_c;

	// Port A read of the destination row
	assign a_en = lookup_valid;
	assign a_row = row_index_hash(lookup_dst_mac, lookup_vlan);

	////////////////////////////////////////////////////////////////////////////
	// Key delay, lines up with the two-cycle RAM read

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_d <= '0;
		end else begin
			vld_d <= {vld_d[0], lookup_valid};
		end
	end

	always_ff @(posedge clk) begin
		vlan_d[0] <= lookup_vlan;
		vlan_d[1] <= vlan_d[0];
		mac_d[0] <= lookup_dst_mac;
		mac_d[1] <= mac_d[0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Way compare

	always_comb begin
		hit_c = 1'b0;
		port_c = '0;
		// Ascending scan so the highest matching way wins
		for (int w = 0; w < `ASSOC_WAYS; w++) begin
			if (a_rdata[w].fld.valid && (a_rdata[w].fld.vlan == vlan_d[1]) &&
				(a_rdata[w].fld.mac == mac_d[1])) begin
				hit_c = 1'b1;
				port_c = a_rdata[w].fld.port;
			end
		end
	end

	// Result stage, port stays zero on a miss
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lookup_done <= 1'b0;
			lookup_hit <= 1'b0;
			lookup_dst_port <= '0;
		end else begin
			lookup_done <= vld_d[1];
			lookup_hit <= vld_d[1] & hit_c;
			lookup_dst_port <= vld_d[1] ? port_c : '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/mac_table_ram.sv
`default_nettype none
`include "mac_table_defs.svh"

module mac_table_ram import mac_table_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire a_en,
	input wire [`ROW_BITS-1:0] a_row,
	input wire b_en,
	input wire [`ROW_BITS-1:0] b_row,
	input wire [`ASSOC_WAYS-1:0] b_we,
	input wire [`ENTRY_W-1:0] b_wdata,
	output mac_entry_u [`ASSOC_WAYS-1:0] a_rdata,
	output mac_entry_u [`ASSOC_WAYS-1:0] b_rdata
);

	for (genvar w = 0; w < `ASSOC_WAYS; w++) begin : g_way
		// VLAN, port and MAC only, valid kept apart
		logic [`ENTRY_W-2:0] mem [`TABLE_ROWS];
		logic [`TABLE_ROWS-1:0] vld;
		mac_entry_u a_s1;
		mac_entry_u a_s2;
		mac_entry_u b_s1;
		mac_entry_u b_s2;

		// Port B is the only writer
		always_ff @(posedge clk) begin
			if (b_en && b_we[w]) begin
				mem[b_row] <= b_wdata[`ENTRY_W-2:0];
			end
		end

		// Valid flags, cleared so a fresh table reads as empty
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				vld <= '0;
			end else if (b_en && b_we[w]) begin
				vld[b_row] <= b_wdata[`ENTRY_W-1];
			end
		end

		// Two read stages per port, read-first on a port B write
		always_ff @(posedge clk) begin
			if (a_en) begin
				a_s1.raw <= {vld[a_row], mem[a_row]};
			end
			if (b_en) begin
				b_s1.raw <= {vld[b_row], mem[b_row]};
			end
			a_s2 <= a_s1;
			b_s2 <= b_s1;
		end

		assign a_rdata[w] = a_s2;
		assign b_rdata[w] = b_s2;
	end

endmodule

`default_nettype wire

// File: logic/mac_table_pkg.sv
`default_nettype none
`include "mac_table_defs.svh"

package mac_table_pkg;

	// Field view of one table entry, valid sits at the MSB
	typedef struct packed {
		logic valid;
		logic [`VLAN_W-1:0] vlan;
		logic [`PORT_W-1:0] port;
		logic [`MAC_W-1:0] mac;
	} mac_entry_s;

	// RAM sees raw bits, matchers and queue see fields
	typedef union packed {
		logic [`ENTRY_W-1:0] raw;
		mac_entry_s fld;
	} mac_entry_u;

	// XOR fold of the three MAC slices and the VLAN, low bits pick the row
	function automatic logic [`ROW_BITS-1:0] row_index_hash(
		input logic [`MAC_W-1:0] mac,
		input logic [`VLAN_W-1:0] vlan
	);
		logic [15:0] fold;
		fold = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ 16'(vlan);
		return fold[`ROW_BITS-1:0];
	endfunction

endpackage

`default_nettype wire

// File: logic/mac_table_defs.svh
`ifndef MAC_TABLE_DEFS_SVH
`define MAC_TABLE_DEFS_SVH

// Address and tag field widths
`define MAC_W 48
`define VLAN_W 12
`define PORT_W 5

// Table geometry
`define TABLE_ROWS 16
`define ROW_BITS 4
`define ASSOC_WAYS 2
`define WAY_BITS 1

// Learn queue
`define PENDING_DEPTH 4
`define PEND_BITS 2

// Stored word is valid + VLAN + port + MAC
`define ENTRY_W 66

`endif
